//--- source/apu_config.svh
`ifndef APU_CONFIG_SVH
`define APU_CONFIG_SVH

// Number of independent lanes in the array
`define APU_LANES 4

// General purpose registers held by each lane
`define APU_REGS 4

// Lane and register indices are sized from these two
// with $clog2, so keep both at 2 or above

`endif

//--- source/apu_pkg.sv
package apu_pkg;

	// ALU opcodes, grouped by the top two bits
	typedef enum logic [3:0] {
		ALU_LOAD,	// Logic group
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_ADD,	// Adder group, low bit selects carry in
		ALU_ADC,
		ALU_SUB,
		ALU_SBC,
		ALU_RR,		// Right shifts
		ALU_RRC,
		ALU_SRA,
		ALU_SRZ,
		ALU_RL,		// Left shifts
		ALU_RLC,
		ALU_MUL,	// Multiplier
		ALU_MULS
	} alu_func_e;

	// Operand width in bytes minus one
	typedef enum logic [1:0] {
		SZ8,
		SZ16,
		SZ24,
		SZ32
	} op_size_e;

endpackage

//--- source/apu_alu.sv
`timescale 1ns/100ps

module apu_alu import apu_pkg::*; (
	input  logic [31:0] src,
	input  logic [31:0] arg,
	input  logic        c,
	input  alu_func_e   func,
	input  op_size_e    sz,
	output logic [31:0] res,
	output logic        fz,
	output logic        fs,
	output logic        fc
);

	logic [31:0] src_ext;	// Operands cut down to the size
	logic [31:0] arg_ext;
	logic        cin;
	logic [32:0] sum;
	logic [32:0] dif;
	logic [32:0] addsub;
	logic        c_addsub;
	logic        top_bit;	// src bit at the top of the size
	logic        fill_l;
	logic        fill_r;
	logic        ins0;
	logic        ins1;
	logic        ins2;
	logic [31:0] r_rl;
	logic [31:0] r_rr;
	logic        sg;
	logic        neg_s8;
	logic        neg_a8;
	logic        neg_s16;
	logic        neg_a16;
	logic [7:0]  mag_s8;
	logic [7:0]  mag_a8;
	logic [15:0] mag_s16;
	logic [15:0] mag_a16;
	logic [15:0] mul_a;
	logic [15:0] mul_b;
	logic        mul_neg;
	logic [31:0] prod;
	logic [31:0] r_mul;

	always_comb begin
		case (sz)
			SZ8: begin
				src_ext = {24'h0, src[7:0]};
				arg_ext = {24'h0, arg[7:0]};
				top_bit = src[7];
			end
			SZ16: begin
				src_ext = {16'h0, src[15:0]};
				arg_ext = {16'h0, arg[15:0]};
				top_bit = src[15];
			end
			SZ24: begin
				src_ext = {8'h0, src[23:0]};
				arg_ext = {8'h0, arg[23:0]};
				top_bit = src[23];
			end
			SZ32: begin
				src_ext = src;
				arg_ext = arg;
				top_bit = src[31];
			end
		endcase
	end

	// Carry in only for ADC and SBC
	assign cin = c && (func == ALU_ADC || func == ALU_SBC);

	assign sum = {1'b0, src_ext} + {1'b0, arg_ext} + {32'h0, cin};
	assign dif = {1'b0, src_ext} - {1'b0, arg_ext} - {32'h0, cin};
	assign addsub = (func == ALU_ADD || func == ALU_ADC) ? sum : dif;

	always_comb begin
		case (sz)	// Carry or borrow just above the size
			SZ8:  c_addsub = addsub[8];
			SZ16: c_addsub = addsub[16];
			SZ24: c_addsub = addsub[24];
			SZ32: c_addsub = addsub[32];
		endcase
	end

	assign fill_l = (func == ALU_RL) ? top_bit : c;

	always_comb begin
		case (func)
			ALU_RR:  fill_r = src[0];
			ALU_RRC: fill_r = c;
			ALU_SRA: fill_r = top_bit;	// Sign extension
			default: fill_r = 1'b0;
		endcase
	end

	// Byte boundary insertions, only the one at the size gets the fill
	assign ins0 = (sz == SZ8)  ? fill_r : src[8];
	assign ins1 = (sz == SZ16) ? fill_r : src[16];
	assign ins2 = (sz == SZ24) ? fill_r : src[24];

	assign r_rl = {src[30:0], fill_l};
	assign r_rr = {fill_r, src[31:25], ins2, src[23:17], ins1, src[15:9], ins0, src[7:1]};

	// Sign and magnitude multiplier
	assign sg      = (func == ALU_MULS);
	assign neg_s8  = sg && src[7];
	assign neg_a8  = sg && arg[7];
	assign neg_s16 = sg && src[15];
	assign neg_a16 = sg && arg[15];

	assign mag_s8  = neg_s8  ? 8'h0 - src[7:0]   : src[7:0];
	assign mag_a8  = neg_a8  ? 8'h0 - arg[7:0]   : arg[7:0];
	assign mag_s16 = neg_s16 ? 16'h0 - src[15:0] : src[15:0];
	assign mag_a16 = neg_a16 ? 16'h0 - arg[15:0] : arg[15:0];

	always_comb begin
		case (sz)
			SZ8, SZ16: begin	// 8 x 8
				mul_a   = {8'h0, mag_s8};
				mul_b   = {8'h0, mag_a8};
				mul_neg = neg_s8 ^ neg_a8;
			end
			SZ24: begin		// 16 x 8
				mul_a   = mag_s16;
				mul_b   = {8'h0, mag_a8};
				mul_neg = neg_s16 ^ neg_a8;
			end
			SZ32: begin		// 16 x 16
				mul_a   = mag_s16;
				mul_b   = mag_a16;
				mul_neg = neg_s16 ^ neg_a16;
			end
		endcase
	end

	assign prod  = {16'h0, mul_a} * {16'h0, mul_b};
	assign r_mul = mul_neg ? 32'h0 - prod : prod;

	always_comb begin
		case (func)
			ALU_LOAD:           res = src;
			ALU_AND:            res = src & arg;
			ALU_OR:             res = src | arg;
			ALU_XOR:            res = src ^ arg;
			ALU_ADD, ALU_ADC,
			ALU_SUB, ALU_SBC:   res = addsub[31:0];
			ALU_RR, ALU_RRC,
			ALU_SRA, ALU_SRZ:   res = r_rr;
			ALU_RL, ALU_RLC:    res = r_rl;
			ALU_MUL, ALU_MULS:  res = r_mul;
		endcase
	end

	// Z and S only look at the bits up to the size
	always_comb begin
		case (sz)
			SZ8: begin
				fz = (res[7:0] == 8'h0);
				fs = res[7];
			end
			SZ16: begin
				fz = (res[15:0] == 16'h0);
				fs = res[15];
			end
			SZ24: begin
				fz = (res[23:0] == 24'h0);
				fs = res[23];
			end
			SZ32: begin
				fz = (res == 32'h0);
				fs = res[31];
			end
		endcase
	end

	always_comb begin
		case (func)
			ALU_LOAD, ALU_AND, ALU_OR, ALU_XOR:   fc = 1'b0;
			ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC:   fc = c_addsub;
			ALU_RR, ALU_RRC, ALU_SRA, ALU_SRZ:    fc = src[0];	// Bit shifted out
			ALU_RL, ALU_RLC:                      fc = top_bit;
			ALU_MUL, ALU_MULS:                    fc = fs;
		endcase
	end

endmodule

//--- source/apu_dispatch.sv
`timescale 1ns/100ps

`include "apu_config.svh"

module apu_dispatch import apu_pkg::*; (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          cmd_valid,
	input  logic [$clog2(`APU_LANES)-1:0] cmd_lane,
	input  alu_func_e                     cmd_func,
	input  op_size_e                      cmd_sz,
	input  logic [$clog2(`APU_REGS)-1:0]  cmd_dst,
	input  logic [$clog2(`APU_REGS)-1:0]  cmd_src,
	input  logic [31:0]                   cmd_arg,
	output logic [`APU_LANES-1:0]         issue,
	output alu_func_e                     iss_func,
	output op_size_e                      iss_sz,
	output logic [$clog2(`APU_REGS)-1:0]  iss_dst,
	output logic [$clog2(`APU_REGS)-1:0]  iss_src,
	output logic [31:0]                   iss_arg
);

	// One-hot strobe, low in idle cycles
	always_ff @(posedge clk) begin
		issue <= '0;
		if (rst_n && cmd_valid)
			issue[cmd_lane] <= 1'b1;
	end

	// Command fields shared by all lanes
	always_ff @(posedge clk) begin
		iss_func <= cmd_func;
		iss_sz   <= cmd_sz;
		iss_dst  <= cmd_dst;
		iss_src  <= cmd_src;
		iss_arg  <= cmd_arg;
	end

endmodule

//--- source/apu_lane.sv
`timescale 1ns/100ps

`include "apu_config.svh"

module apu_lane import apu_pkg::*; (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               issue,
	input  alu_func_e                          iss_func,
	input  op_size_e                           iss_sz,
	input  logic [$clog2(`APU_REGS)-1:0]       iss_dst,
	input  logic [$clog2(`APU_REGS)-1:0]       iss_src,
	input  logic [31:0]                        iss_arg,
	output logic [`APU_REGS-1:0][31:0]         regs,
	output logic                               flag_c,
	output logic                               flag_z,
	output logic                               flag_s
);

	logic [31:0] alu_res;
	logic        alu_fz;
	logic        alu_fs;
	logic        alu_fc;

	// Source register, immediate and own carry in
	apu_alu u_alu (
		.src  (regs[iss_src]),
		.arg  (iss_arg),
		.c    (flag_c),
		.func (iss_func),
		.sz   (iss_sz),
		.res  (alu_res),
		.fz   (alu_fz),
		.fs   (alu_fs),
		.fc   (alu_fc)
	);

	// Write back result and all flags
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			regs   <= '0;
			flag_c <= 1'b0;
			flag_z <= 1'b0;
			flag_s <= 1'b0;
		end else if (issue) begin
			regs[iss_dst] <= alu_res;
			flag_c        <= alu_fc;
			flag_z        <= alu_fz;
			flag_s        <= alu_fs;
		end
	end

endmodule

//--- source/apu_readback.sv
`timescale 1ns/100ps

`include "apu_config.svh"

module apu_readback (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   rd_en,
	input  logic [$clog2(`APU_LANES)-1:0]          rd_lane,
	input  logic [$clog2(`APU_REGS)-1:0]           rd_reg,
	input  logic [`APU_LANES-1:0][`APU_REGS-1:0][31:0] lane_regs,
	input  logic [`APU_LANES-1:0]                  lane_fc,
	input  logic [`APU_LANES-1:0]                  lane_fz,
	input  logic [`APU_LANES-1:0]                  lane_fs,
	output logic                                   rd_valid,
	output logic [31:0]                            rd_data,
	output logic                                   rd_fc,
	output logic                                   rd_fz,
	output logic                                   rd_fs
);

	always_ff @(posedge clk) begin
		if (!rst_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_en;
	end

	// Data holds its last value between reads
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= lane_regs[rd_lane][rd_reg];
			rd_fc   <= lane_fc[rd_lane];
			rd_fz   <= lane_fz[rd_lane];
			rd_fs   <= lane_fs[rd_lane];
		end
	end

endmodule

//--- source/apu_top.sv
`timescale 1ns/100ps

`include "apu_config.svh"

module apu_top import apu_pkg::*; (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          cmd_valid,	// Command port
	input  logic [$clog2(`APU_LANES)-1:0] cmd_lane,
	input  alu_func_e                     cmd_func,
	input  op_size_e                      cmd_sz,
	input  logic [$clog2(`APU_REGS)-1:0]  cmd_dst,
	input  logic [$clog2(`APU_REGS)-1:0]  cmd_src,
	input  logic [31:0]                   cmd_arg,
	input  logic                          rd_en,	// Read port
	input  logic [$clog2(`APU_LANES)-1:0] rd_lane,
	input  logic [$clog2(`APU_REGS)-1:0]  rd_reg,
	output logic                          rd_valid,
	output logic [31:0]                   rd_data,
	output logic                          rd_fc,
	output logic                          rd_fz,
	output logic                          rd_fs
);

	logic [`APU_LANES-1:0]                  issue;
	alu_func_e                              iss_func;
	op_size_e                               iss_sz;
	logic [$clog2(`APU_REGS)-1:0]           iss_dst;
	logic [$clog2(`APU_REGS)-1:0]           iss_src;
	logic [31:0]                            iss_arg;
	logic [`APU_LANES-1:0][`APU_REGS-1:0][31:0] lane_regs;
	logic [`APU_LANES-1:0]                  lane_fc;
	logic [`APU_LANES-1:0]                  lane_fz;
	logic [`APU_LANES-1:0]                  lane_fs;

	apu_dispatch u_dispatch (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd_lane  (cmd_lane),
		.cmd_func  (cmd_func),
		.cmd_sz    (cmd_sz),
		.cmd_dst   (cmd_dst),
		.cmd_src   (cmd_src),
		.cmd_arg   (cmd_arg),
		.issue     (issue),
		.iss_func  (iss_func),
		.iss_sz    (iss_sz),
		.iss_dst   (iss_dst),
		.iss_src   (iss_src),
		.iss_arg   (iss_arg)
	);

	// Lanes share the command fields, each has its own strobe
	for (genvar i = 0; i < `APU_LANES; i++) begin : g_lane
		apu_lane u_lane (
			.clk      (clk),
			.rst_n    (rst_n),
			.issue    (issue[i]),
			.iss_func (iss_func),
			.iss_sz   (iss_sz),
			.iss_dst  (iss_dst),
			.iss_src  (iss_src),
			.iss_arg  (iss_arg),
			.regs     (lane_regs[i]),
			.flag_c   (lane_fc[i]),
			.flag_z   (lane_fz[i]),
			.flag_s   (lane_fs[i])
		);
	end

	apu_readback u_readback (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_en     (rd_en),
		.rd_lane   (rd_lane),
		.rd_reg    (rd_reg),
		.lane_regs (lane_regs),
		.lane_fc   (lane_fc),
		.lane_fz   (lane_fz),
		.lane_fs   (lane_fs),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data),
		.rd_fc     (rd_fc),
		.rd_fz     (rd_fz),
		.rd_fs     (rd_fs)
	);

endmodule

//--- sim/apu_props.sv
`timescale 1ns/100ps

`include "apu_config.svh"

module apu_props (
	input logic                  clk,
	input logic                  rst_n,
	input logic [`APU_LANES-1:0] issue,
	input logic                  rd_en,
	input logic                  rd_valid
);

	// At most one lane gets a command per cycle
	a_issue_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(issue))
		else $error("issue strobe has more than one lane set");

	// Read strobe comes back exactly one cycle later
	a_rd_follow: assert property (@(posedge clk)
		$past(rst_n) |-> (rd_valid == $past(rd_en)))
		else $error("rd_valid does not follow rd_en by one cycle");

	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |=> (issue == '0 && !rd_valid))
		else $error("issue or rd_valid high during reset");

endmodule

bind apu_top apu_props u_props (
	.clk      (clk),
	.rst_n    (rst_n),
	.issue    (issue),
	.rd_en    (rd_en),
	.rd_valid (rd_valid)
);

//--- sim/apu_tb.sv
`timescale 1ns/100ps

`include "apu_config.svh"

module apu_tb import apu_pkg::*; ();

	localparam int clk_period   = 20;
	localparam int lane_w       = $clog2(`APU_LANES);
	localparam int reg_w        = $clog2(`APU_REGS);
	localparam int n_logic      = 64;
	localparam int n_arith      = 64;	// Command pairs
	localparam int n_shift      = 96;
	localparam int n_mul        = 64;
	localparam int n_mixed      = 512;
	localparam int n_reads      = 6 * `APU_LANES * `APU_REGS;
	localparam int n_cmds       = n_logic + 2 * (n_arith + n_shift + n_mul) + n_mixed;
	localparam int limit_cycles = 2 * (n_cmds + n_reads) + 100;

	logic              clk;
	logic              rst_n;
	logic              cmd_valid;
	logic [lane_w-1:0] cmd_lane;
	alu_func_e         cmd_func;
	op_size_e          cmd_sz;
	logic [reg_w-1:0]  cmd_dst;
	logic [reg_w-1:0]  cmd_src;
	logic [31:0]       cmd_arg;
	logic              rd_en;
	logic [lane_w-1:0] rd_lane;
	logic [reg_w-1:0]  rd_reg;
	logic              rd_valid;
	logic [31:0]       rd_data;
	logic              rd_fc;
	logic              rd_fz;
	logic              rd_fs;

	// Reference copy of every lane
	logic [31:0] model_regs [`APU_LANES][`APU_REGS];
	logic        model_fc [`APU_LANES];
	logic        model_fz [`APU_LANES];
	logic        model_fs [`APU_LANES];
	logic [31:0] lfsr = 32'hca838509;

	apu_top dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd_lane  (cmd_lane),
		.cmd_func  (cmd_func),
		.cmd_sz    (cmd_sz),
		.cmd_dst   (cmd_dst),
		.cmd_src   (cmd_src),
		.cmd_arg   (cmd_arg),
		.rd_en     (rd_en),
		.rd_lane   (rd_lane),
		.rd_reg    (rd_reg),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data),
		.rd_fc     (rd_fc),
		.rd_fz     (rd_fz),
		.rd_fs     (rd_fs)
	);

	always #(clk_period / 2) clk = ~clk;

	initial begin
		#(limit_cycles * clk_period);
		$display("Timeout: the test sequence did not finish within %0d cycles", limit_cycles);
		$display("SOME TESTS FAILED");
		$fatal(1);
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int k = 0; k < n; k++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	// Two's complement value of the low bits
	function automatic longint mul_operand(input logic [31:0] v, input int bits, input logic sgn);
		longint u;
		u = longint'(v & ((32'h1 << bits) - 32'h1));
		if (sgn && v[bits - 1])
			u = u - (longint'(1) << bits);
		return u;
	endfunction

	function automatic void alu_model(input logic [31:0] a, input logic [31:0] b,
			input logic cin, input alu_func_e func, input op_size_e sz,
			output logic [31:0] r, output logic c, output logic z, output logic s);
		int          width;
		logic [31:0] mask;
		logic [32:0] wide;
		logic        top;
		logic        fill;
		longint      x;
		longint      y;
		width = 8 * (int'(sz) + 1);
		mask  = 32'hffffffff >> (32 - width);
		top   = a[width - 1];
		c     = 1'b0;
		case (func)
			ALU_LOAD: r = a;
			ALU_AND:  r = a & b;
			ALU_OR:   r = a | b;
			ALU_XOR:  r = a ^ b;
			ALU_ADD, ALU_ADC: begin
				wide = {1'b0, a & mask} + {1'b0, b & mask} + {32'h0, cin && func == ALU_ADC};
				r    = wide[31:0];
				c    = wide[width];	// Carry just above the size
			end
			ALU_SUB, ALU_SBC: begin
				wide = {1'b0, a & mask} - {1'b0, b & mask} - {32'h0, cin && func == ALU_SBC};
				r    = wide[31:0];
				c    = wide[width];
			end
			ALU_RL, ALU_RLC: begin
				r = {a[30:0], (func == ALU_RL) ? top : cin};
				c = top;
			end
			ALU_MUL, ALU_MULS: begin
				x = mul_operand(a, (sz == SZ24 || sz == SZ32) ? 16 : 8, func == ALU_MULS);
				y = mul_operand(b, (sz == SZ32) ? 16 : 8, func == ALU_MULS);
				r = 32'(x * y);
			end
			default: begin	// Right shifts
				case (func)
					ALU_RR:  fill = a[0];
					ALU_RRC: fill = cin;
					ALU_SRA: fill = top;
					default: fill = 1'b0;
				endcase
				r            = a >> 1;
				r[width - 1] = fill;
				r[31]        = fill;	// Top byte boundary always takes the fill
				c            = a[0];
			end
		endcase
		z = (r & mask) == 32'h0;
		s = r[width - 1];
		if (func == ALU_MUL || func == ALU_MULS)
			c = s;
	endfunction

	// Drives one command and updates the model at the same time
	task automatic send_cmd(input logic [lane_w-1:0] lane, input alu_func_e func,
			input op_size_e sz, input logic [reg_w-1:0] dst, input logic [reg_w-1:0] src,
			input logic [31:0] arg);
		logic [31:0] r;
		logic        c;
		logic        z;
		logic        s;
		cmd_valid = 1'b1;
		cmd_lane  = lane;
		cmd_func  = func;
		cmd_sz    = sz;
		cmd_dst   = dst;
		cmd_src   = src;
		cmd_arg   = arg;
		alu_model(model_regs[lane][src], arg, model_fc[lane], func, sz, r, c, z, s);
		model_regs[lane][dst] = r;
		model_fc[lane]        = c;
		model_fz[lane]        = z;
		model_fs[lane]        = s;
		@(negedge clk);
	endtask

	task automatic idle(input int n);
		cmd_valid = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	task automatic read_check(input logic [lane_w-1:0] lane, input logic [reg_w-1:0] idx);
		rd_en   = 1'b1;
		rd_lane = lane;
		rd_reg  = idx;
		@(posedge clk);
		@(negedge clk);
		check("rd_valid", 32'(rd_valid), 32'h1);
		check("rd_data", rd_data, model_regs[lane][idx]);
		check("rd_fc", 32'(rd_fc), 32'(model_fc[lane]));
		check("rd_fz", 32'(rd_fz), 32'(model_fz[lane]));
		check("rd_fs", 32'(rd_fs), 32'(model_fs[lane]));
		rd_en = 1'b0;
	endtask

	// Lets the pipeline drain, then reads every register
	task automatic read_all();
		idle(2);
		for (int l = 0; l < `APU_LANES; l++)
			for (int r = 0; r < `APU_REGS; r++)
				read_check(lane_w'(l), reg_w'(r));
		@(posedge clk);
		@(negedge clk);
		check("rd_valid", 32'(rd_valid), 32'h0);
	endtask

	initial begin
		logic [lane_w-1:0] lane;
		logic [reg_w-1:0]  r;
		clk       = 1'b0;
		rst_n     = 1'b0;
		cmd_valid = 1'b1;	// Command and read held in reset must be dropped
		cmd_lane  = '0;
		cmd_func  = ALU_XOR;
		cmd_sz    = SZ32;
		cmd_dst   = '0;
		cmd_src   = '0;
		cmd_arg   = 32'hffffffff;
		rd_en     = 1'b1;
		rd_lane   = '0;
		rd_reg    = '0;
		for (int l = 0; l < `APU_LANES; l++) begin
			for (int k = 0; k < `APU_REGS; k++)
				model_regs[l][k] = 32'h0;
			model_fc[l] = 1'b0;
			model_fz[l] = 1'b0;
			model_fs[l] = 1'b0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n     = 1'b1;
		cmd_valid = 1'b0;
		rd_en     = 1'b0;
		read_all();

		// Logic group, every lane and size in turn
		for (int i = 0; i < n_logic; i++)
			send_cmd(lane_w'(i), alu_func_e'(4'(rand_bits(2))), op_size_e'(i[3:2]),
				reg_w'(rand_bits(reg_w)), reg_w'(rand_bits(reg_w)), rand_bits(32));
		read_all();

		// Carry chains, second command on the same lane right after
		for (int i = 0; i < n_arith; i++) begin
			lane = lane_w'(rand_bits(lane_w));
			r    = reg_w'(rand_bits(reg_w));
			send_cmd(lane, (rand_bits(1) != 0) ? ALU_SUB : ALU_ADD, op_size_e'(i[1:0]),
				r, reg_w'(rand_bits(reg_w)), rand_bits(32));
			send_cmd(lane, (rand_bits(1) != 0) ? ALU_SBC : ALU_ADC, op_size_e'(i[1:0]),
				reg_w'(rand_bits(reg_w)), r, rand_bits(32));
		end
		read_all();

		for (int i = 0; i < n_shift; i++) begin
			lane = lane_w'(rand_bits(lane_w));
			r    = reg_w'(rand_bits(reg_w));
			send_cmd(lane, ALU_XOR, SZ32, r, r, rand_bits(32));	// Fresh random value
			send_cmd(lane, alu_func_e'(4'(8 + rand_bits(4) % 6)), op_size_e'(i[1:0]),
				reg_w'(rand_bits(reg_w)), r, rand_bits(32));
		end
		read_all();

		for (int i = 0; i < n_mul; i++) begin
			lane = lane_w'(rand_bits(lane_w));
			r    = reg_w'(rand_bits(reg_w));
			send_cmd(lane, ALU_XOR, SZ32, r, r, rand_bits(32));
			send_cmd(lane, (rand_bits(1) != 0) ? ALU_MULS : ALU_MUL, op_size_e'(i[1:0]),
				reg_w'(rand_bits(reg_w)), r, rand_bits(32));
		end
		read_all();

		// Back to back across all lanes
		for (int i = 0; i < n_mixed; i++)
			send_cmd(lane_w'(rand_bits(lane_w)), alu_func_e'(4'(rand_bits(4))),
				op_size_e'(2'(rand_bits(2))), reg_w'(rand_bits(reg_w)),
				reg_w'(rand_bits(reg_w)), rand_bits(32));
		read_all();

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- apu.f
+incdir+source
source/apu_pkg.sv
source/apu_alu.sv
source/apu_dispatch.sv
source/apu_lane.sv
source/apu_readback.sv
source/apu_top.sv
sim/apu_props.sv
sim/apu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the APU testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f apu.f \
	--top-module apu_tb \
	-Mdir obj_dir \
	-o apu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/apu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit $status
fi

exit 0
